//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       ?= tb_dcasic_lite
FILELIST  ?= dcasic_lite.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- cfg_regs.sv
`timescale 1ns/1ps

module cfg_regs (
    input  logic                               sys_clk_i,
    input  logic                               rst_n_i,
    input  logic                               cfg_we_i,
    input  logic                               cfg_re_i,
    input  logic [dcasic_pkg::CONF_ADDR_W-1:0] cfg_addr_i,
    input  logic [dcasic_pkg::CONF_DATA_W-1:0] cfg_wdata_i,
    input  logic                               ovf_i,
    input  logic [dcasic_pkg::PIX_CNT_W-1:0]   pix_count_i,
    output logic [dcasic_pkg::CONF_DATA_W-1:0] cfg_rdata_o,
    output logic                               cfg_rvalid_o,
    output logic                               dsp_en_o,
    output logic                               dsp_bgr_o,
    output logic                               dsp_resx_o,
    output logic [dcasic_pkg::DBI_IF_D_W-1:0]  dsp_cmd_o,
    output logic                               cam_en_o,
    output logic                               stat_clr_o
);
    import dcasic_pkg::*;

    logic [REGION_ID_W-1:0] region;
    logic [CONF_OFS_W-1:0]  ofs;
    logic                   dsp_sel;
    logic                   cam_sel;
    logic [DSP_CTRL_W-1:0]  dsp_ctrl;
    logic                   cam_ctrl;
    logic [CONF_DATA_W-1:0] rdata_nxt;

    assign region  = cfg_addr_i[CONF_ADDR_W-1 -: REGION_ID_W];
    assign ofs     = cfg_addr_i[CONF_OFS_W-1:0];
    assign dsp_sel = (region == DSP_CONF_ID);
    assign cam_sel = (region == CAM_CONF_ID);

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dsp_ctrl  <= '0;
            dsp_cmd_o <= '0;
            cam_ctrl  <= 1'b0;
        end else if (cfg_we_i) begin
            if (dsp_sel && ofs == DSP_CTRL_OFS)
                dsp_ctrl <= cfg_wdata_i[DSP_CTRL_W-1:0];
            if (dsp_sel && ofs == DSP_CMD_OFS)
                dsp_cmd_o <= cfg_wdata_i[DBI_IF_D_W-1:0];    // Low byte only
            if (cam_sel && ofs == CAM_CTRL_OFS)
                cam_ctrl <= cfg_wdata_i[CAM_EN_BIT];
        end
    end

    assign dsp_en_o   = dsp_ctrl[DSP_EN_BIT];
    assign dsp_resx_o = dsp_ctrl[DSP_RESX_BIT];
    assign dsp_bgr_o  = dsp_ctrl[DSP_BGR_BIT];
    assign cam_en_o   = cam_ctrl;

    // Capture block clears count and overflow on the same edge
    assign stat_clr_o = cfg_we_i && cam_sel && (ofs == CAM_STAT_OFS);

    always_comb begin
        rdata_nxt = '0;
        if (dsp_sel) begin
            if (ofs == DSP_CTRL_OFS)
                rdata_nxt[DSP_CTRL_W-1:0] = dsp_ctrl;
            else if (ofs == DSP_CMD_OFS)
                rdata_nxt[DBI_IF_D_W-1:0] = dsp_cmd_o;
        end else if (cam_sel) begin
            if (ofs == CAM_CTRL_OFS) begin
                rdata_nxt[CAM_EN_BIT] = cam_ctrl;
            end else if (ofs == CAM_STAT_OFS) begin
                rdata_nxt[CONF_DATA_W-1 -: PIX_CNT_W] = pix_count_i;
                rdata_nxt[STAT_OVF_BIT]               = ovf_i;
            end
        end
    end

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg_rvalid_o <= 1'b0;
            cfg_rdata_o  <= '0;
        end else begin
            cfg_rvalid_o <= cfg_re_i;    // One cycle read latency
            if (cfg_re_i)
                cfg_rdata_o <= rdata_nxt;
        end
    end

endmodule

//--- dbi_tx_engine.sv
`timescale 1ns/1ps

module dbi_tx_engine (
    input  logic                              sys_clk_i,
    input  logic                              rst_n_i,
    input  logic                              pix_valid_i,
    input  dcasic_pkg::pixel_t                pix_data_i,
    input  logic                              pix_first_i,
    input  logic                              dsp_en_i,
    input  logic                              dsp_bgr_i,
    input  logic [dcasic_pkg::DBI_IF_D_W-1:0] dsp_cmd_i,
    output logic                              pix_full_o,
    output logic                              dbi_dcx_o,
    output logic                              dbi_csx_o,
    output logic                              dbi_wrx_o,
    output logic [dcasic_pkg::DBI_IF_D_W-1:0] dbi_d_o
);
    import dcasic_pkg::*;

    logic [TX_ST_W-1:0] state;
    pixel_t             pop_data;
    pixel_t             pix_sw;
    pixel_t             pix_q;
    logic               pop_first;
    logic               fifo_empty;
    logic               start;

    pixel_fifo u_fifo (
        .sys_clk_i    (sys_clk_i),
        .rst_n_i      (rst_n_i),
        .push_i       (pix_valid_i),
        .push_data_i  (pix_data_i),
        .push_first_i (pix_first_i),
        .pop_i        (start),
        .pop_data_o   (pop_data),
        .pop_first_o  (pop_first),
        .empty_o      (fifo_empty),
        .full_o       (pix_full_o)
    );

    always_comb begin
        pix_sw = pop_data;
        if (dsp_bgr_i) begin
            pix_sw.c.red  = pop_data.c.blue;
            pix_sw.c.blue = pop_data.c.red;
        end
    end

    // Next pixel may start from idle or straight after the lo byte
    assign start = dsp_en_i && !fifo_empty && (state == TX_IDLE || state == TX_LO_H);

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state     <= TX_IDLE;
            dbi_csx_o <= 1'b1;
            dbi_wrx_o <= 1'b1;
            dbi_dcx_o <= 1'b1;
        end else begin
            case (state)
                TX_IDLE, TX_LO_H: begin
                    if (start) begin
                        dbi_csx_o <= 1'b0;
                        dbi_wrx_o <= 1'b0;
                        dbi_dcx_o <= !pop_first;    // Command byte first
                        state     <= pop_first ? TX_CMD_L : TX_HI_L;
                    end else begin
                        dbi_csx_o <= 1'b1;    // Burst over
                        dbi_dcx_o <= 1'b1;
                        state     <= TX_IDLE;
                    end
                end
                TX_CMD_L: begin
                    dbi_wrx_o <= 1'b1;
                    state     <= TX_CMD_H;
                end
                TX_CMD_H: begin
                    dbi_wrx_o <= 1'b0;
                    dbi_dcx_o <= 1'b1;
                    state     <= TX_HI_L;
                end
                TX_HI_L: begin
                    dbi_wrx_o <= 1'b1;
                    state     <= TX_HI_H;
                end
                TX_HI_H: begin
                    dbi_wrx_o <= 1'b0;
                    state     <= TX_LO_L;
                end
                TX_LO_L: begin
                    dbi_wrx_o <= 1'b1;
                    state     <= TX_LO_H;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Data held over both phases of a byte
    always_ff @(posedge sys_clk_i) begin
        if (start) begin
            pix_q   <= pix_sw;
            dbi_d_o <= pop_first ? dsp_cmd_i : pix_sw.b.hi;
        end else if (state == TX_CMD_H) begin
            dbi_d_o <= pix_q.b.hi;
        end else if (state == TX_HI_H) begin
            dbi_d_o <= pix_q.b.lo;
        end
    end

endmodule

//--- dcasic_lite.f
dcasic_pkg.sv
pixel_fifo.sv
cfg_regs.sv
dvp_capture.sv
dbi_tx_engine.sv
dcasic_lite.sv
tb_dcasic_lite.sv

//--- dcasic_lite.sv
`timescale 1ns/1ps

module dcasic_lite (
    input  logic                               sys_clk_i,
    input  logic                               rst_n_i,
    // Configuration port
    input  logic                               cfg_we_i,
    input  logic                               cfg_re_i,
    input  logic [dcasic_pkg::CONF_ADDR_W-1:0] cfg_addr_i,
    input  logic [dcasic_pkg::CONF_DATA_W-1:0] cfg_wdata_i,
    output logic [dcasic_pkg::CONF_DATA_W-1:0] cfg_rdata_o,
    output logic                               cfg_rvalid_o,
    // Camera RX
    input  logic [dcasic_pkg::DVP_DATA_W-1:0]  dvp_d_i,
    input  logic                               dvp_href_i,
    input  logic                               dvp_vsync_i,
    // Display TX
    output logic                               dbi_dcx_o,
    output logic                               dbi_csx_o,
    output logic                               dbi_resx_o,
    output logic                               dbi_rdx_o,
    output logic                               dbi_wrx_o,
    output logic [dcasic_pkg::DBI_IF_D_W-1:0]  dbi_d_o
);
    import dcasic_pkg::*;

    logic                  dsp_en;
    logic                  dsp_bgr;
    logic [DBI_IF_D_W-1:0] dsp_cmd;
    logic                  cam_en;
    logic                  stat_clr;
    logic                  ovf;
    logic [PIX_CNT_W-1:0]  pix_count;
    logic                  pix_valid;
    pixel_t                pix_data;
    logic                  pix_first;
    logic                  pix_full;

    assign dbi_rdx_o = 1'b1;    // Write-only display bus

    cfg_regs u_cfg_regs (
        .sys_clk_i    (sys_clk_i),
        .rst_n_i      (rst_n_i),
        .cfg_we_i     (cfg_we_i),
        .cfg_re_i     (cfg_re_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_wdata_i  (cfg_wdata_i),
        .ovf_i        (ovf),
        .pix_count_i  (pix_count),
        .cfg_rdata_o  (cfg_rdata_o),
        .cfg_rvalid_o (cfg_rvalid_o),
        .dsp_en_o     (dsp_en),
        .dsp_bgr_o    (dsp_bgr),
        .dsp_resx_o   (dbi_resx_o),
        .dsp_cmd_o    (dsp_cmd),
        .cam_en_o     (cam_en),
        .stat_clr_o   (stat_clr)
    );

    dvp_capture u_dvp_capture (
        .sys_clk_i   (sys_clk_i),
        .rst_n_i     (rst_n_i),
        .dvp_d_i     (dvp_d_i),
        .dvp_href_i  (dvp_href_i),
        .dvp_vsync_i (dvp_vsync_i),
        .cam_en_i    (cam_en),
        .stat_clr_i  (stat_clr),
        .pix_full_i  (pix_full),
        .pix_valid_o (pix_valid),
        .pix_data_o  (pix_data),
        .pix_first_o (pix_first),
        .ovf_o       (ovf),
        .pix_count_o (pix_count)
    );

    dbi_tx_engine u_dbi_tx_engine (
        .sys_clk_i   (sys_clk_i),
        .rst_n_i     (rst_n_i),
        .pix_valid_i (pix_valid),
        .pix_data_i  (pix_data),
        .pix_first_i (pix_first),
        .dsp_en_i    (dsp_en),
        .dsp_bgr_i   (dsp_bgr),
        .dsp_cmd_i   (dsp_cmd),
        .pix_full_o  (pix_full),
        .dbi_dcx_o   (dbi_dcx_o),
        .dbi_csx_o   (dbi_csx_o),
        .dbi_wrx_o   (dbi_wrx_o),
        .dbi_d_o     (dbi_d_o)
    );

endmodule

//--- dcasic_pkg.sv
package dcasic_pkg;

    // Bus widths
    localparam int CONF_ADDR_W = 32;
    localparam int CONF_DATA_W = 32;
    localparam int DVP_DATA_W  = 8;
    localparam int DBI_IF_D_W  = 8;

    // Region decode on address bits 31:29
    localparam int REGION_ID_W = 3;
    localparam int CONF_OFS_W  = CONF_ADDR_W - REGION_ID_W;
    localparam logic [REGION_ID_W-1:0] DSP_CONF_ID = 3'd1;    // 0x2000_0000
    localparam logic [REGION_ID_W-1:0] CAM_CONF_ID = 3'd2;    // 0x4000_0000

    // Byte offsets in the display region
    localparam logic [CONF_OFS_W-1:0] DSP_CTRL_OFS = 'h0;
    localparam logic [CONF_OFS_W-1:0] DSP_CMD_OFS  = 'h1;
    localparam int DSP_CTRL_W   = 3;
    localparam int DSP_EN_BIT   = 0;
    localparam int DSP_RESX_BIT = 1;
    localparam int DSP_BGR_BIT  = 2;

    // Word offsets in the camera region
    localparam logic [CONF_OFS_W-1:0] CAM_CTRL_OFS = 'h0;
    localparam logic [CONF_OFS_W-1:0] CAM_STAT_OFS = 'h4;
    localparam int CAM_EN_BIT   = 0;
    localparam int STAT_OVF_BIT = 0;
    localparam int PIX_CNT_W    = 16;    // Status bits 31:16

    localparam int PIX_FIFO_DEPTH = 4;
    localparam int PIX_PTR_W      = $clog2(PIX_FIFO_DEPTH);

    // DBI engine states with a low and a high phase per byte
    localparam int TX_ST_W = 3;
    localparam logic [TX_ST_W-1:0] TX_IDLE  = 3'd0;
    localparam logic [TX_ST_W-1:0] TX_CMD_L = 3'd1;
    localparam logic [TX_ST_W-1:0] TX_CMD_H = 3'd2;
    localparam logic [TX_ST_W-1:0] TX_HI_L  = 3'd3;
    localparam logic [TX_ST_W-1:0] TX_HI_H  = 3'd4;
    localparam logic [TX_ST_W-1:0] TX_LO_L  = 3'd5;
    localparam logic [TX_ST_W-1:0] TX_LO_H  = 3'd6;

    // RGB565 word seen as two bytes or as colour fields
    typedef union packed {
        struct packed {
            logic [DVP_DATA_W-1:0] hi;
            logic [DVP_DATA_W-1:0] lo;
        } b;
        struct packed {
            logic [4:0] red;
            logic [5:0] green;
            logic [4:0] blue;
        } c;
    } pixel_t;

endpackage

//--- dvp_capture.sv
`timescale 1ns/1ps

module dvp_capture (
    input  logic                              sys_clk_i,
    input  logic                              rst_n_i,
    input  logic [dcasic_pkg::DVP_DATA_W-1:0] dvp_d_i,
    input  logic                              dvp_href_i,
    input  logic                              dvp_vsync_i,
    input  logic                              cam_en_i,
    input  logic                              stat_clr_i,
    input  logic                              pix_full_i,
    output logic                              pix_valid_o,
    output dcasic_pkg::pixel_t                pix_data_o,
    output logic                              pix_first_o,
    output logic                              ovf_o,
    output logic [dcasic_pkg::PIX_CNT_W-1:0]  pix_count_o
);
    import dcasic_pkg::*;

    logic                  vsync_q;
    logic                  vs_rise;
    logic                  take;
    logic                  byte_sel;    // High once the hi byte is held
    logic                  first_pend;
    logic [DVP_DATA_W-1:0] hi_q;

    assign vs_rise = dvp_vsync_i && !vsync_q;
    assign take    = cam_en_i && dvp_href_i && !vs_rise;

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vsync_q     <= 1'b0;
            byte_sel    <= 1'b0;
            first_pend  <= 1'b0;
            pix_valid_o <= 1'b0;
            pix_first_o <= 1'b0;
        end else begin
            vsync_q     <= dvp_vsync_i;
            pix_valid_o <= 1'b0;
            if (vs_rise) begin
                byte_sel   <= 1'b0;    // Restart pairing
                first_pend <= 1'b1;
            end else if (take) begin
                byte_sel <= !byte_sel;
                if (byte_sel) begin
                    pix_valid_o <= 1'b1;
                    pix_first_o <= first_pend;
                    first_pend  <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (take) begin
            if (!byte_sel) begin
                hi_q <= dvp_d_i;
            end else begin
                pix_data_o.b.hi <= hi_q;
                pix_data_o.b.lo <= dvp_d_i;
            end
        end
    end

    // Status seen by the register block
    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pix_count_o <= '0;
            ovf_o       <= 1'b0;
        end else begin
            if (stat_clr_i || vs_rise)
                pix_count_o <= '0;
            else if (pix_valid_o)
                pix_count_o <= pix_count_o + 1'b1;

            if (stat_clr_i)
                ovf_o <= 1'b0;
            else if (pix_valid_o && pix_full_i)
                ovf_o <= 1'b1;    // Sticky once a pixel is lost
        end
    end

endmodule

//--- pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo (
    input  logic               sys_clk_i,
    input  logic               rst_n_i,
    input  logic               push_i,
    input  dcasic_pkg::pixel_t push_data_i,
    input  logic               push_first_i,
    input  logic               pop_i,
    output dcasic_pkg::pixel_t pop_data_o,
    output logic               pop_first_o,
    output logic               empty_o,
    output logic               full_o
);
    import dcasic_pkg::*;

    pixel_t               mem   [PIX_FIFO_DEPTH];
    logic                 first [PIX_FIFO_DEPTH];
    logic [PIX_PTR_W-1:0] wr_ptr;
    logic [PIX_PTR_W-1:0] rd_ptr;
    logic [PIX_PTR_W:0]   count;
    logic                 do_push;
    logic                 do_pop;

    assign empty_o = (count == '0);
    assign full_o  = (count == PIX_FIFO_DEPTH);
    assign do_push = push_i && !full_o;    // Dropped when full
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge sys_clk_i) begin
        if (do_push) begin
            mem[wr_ptr]   <= push_data_i;
            first[wr_ptr] <= push_first_i;
        end
    end

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + do_push - do_pop;
        end
    end

    // Show-ahead read
    assign pop_data_o  = mem[rd_ptr];
    assign pop_first_o = first[rd_ptr];

endmodule

//--- tb_dcasic_lite.sv
`timescale 1ns/1ps

module tb_dcasic_lite;

    localparam int K_WR      = 0;
    localparam int K_RD      = 1;
    localparam int K_PIX     = 2;    // Data holds the byte gap and exp says if the pixel is shown
    localparam int K_IDLE    = 3;
    localparam int K_VS      = 4;
    localparam int K_DRAIN   = 5;
    localparam int MAX_STEPS = 64;

    logic        sys_clk;
    logic        rst_n;
    logic        cfg_we;
    logic        cfg_re;
    logic [31:0] cfg_addr;
    logic [31:0] cfg_wdata;
    logic [31:0] cfg_rdata;
    logic        cfg_rvalid;
    logic [7:0]  dvp_d;
    logic        dvp_href;
    logic        dvp_vsync;
    logic        dbi_dcx;
    logic        dbi_csx;
    logic        dbi_resx;
    logic        dbi_rdx;
    logic        dbi_wrx;
    logic [7:0]  dbi_d;

    int          st_kind [MAX_STEPS];
    logic [31:0] st_addr [MAX_STEPS];
    logic [31:0] st_data [MAX_STEPS];
    logic [31:0] st_exp  [MAX_STEPS];
    int          n_steps;

    logic [8:0]  dbi_exp [$];    // {dcx, data} in bus order
    logic        wrx_prev;
    logic [8:0]  mon_got;
    logic [8:0]  mon_want;
    int          errors;
    int          checks;
    integer      seed;

    // Model of the display registers and frame state
    logic        bgr_m;
    logic [7:0]  cmd_m;
    logic        first_m;

    dcasic_lite dut (
        .sys_clk_i    (sys_clk),
        .rst_n_i      (rst_n),
        .cfg_we_i     (cfg_we),
        .cfg_re_i     (cfg_re),
        .cfg_addr_i   (cfg_addr),
        .cfg_wdata_i  (cfg_wdata),
        .cfg_rdata_o  (cfg_rdata),
        .cfg_rvalid_o (cfg_rvalid),
        .dvp_d_i      (dvp_d),
        .dvp_href_i   (dvp_href),
        .dvp_vsync_i  (dvp_vsync),
        .dbi_dcx_o    (dbi_dcx),
        .dbi_csx_o    (dbi_csx),
        .dbi_resx_o   (dbi_resx),
        .dbi_rdx_o    (dbi_rdx),
        .dbi_wrx_o    (dbi_wrx),
        .dbi_d_o      (dbi_d)
    );

    initial begin
        sys_clk = 1'b0;
        forever #20 sys_clk = ~sys_clk;
    end

    task automatic add_step(input int kind, input logic [31:0] addr,
                            input logic [31:0] data, input logic [31:0] exp);
        st_kind[n_steps] = kind;
        st_addr[n_steps] = addr;
        st_data[n_steps] = data;
        st_exp[n_steps]  = exp;
        n_steps++;
    endtask

    task automatic build_table();
        // Registers read zero out of reset
        add_step(K_RD, 32'h2000_0000, 0, 32'h0);
        add_step(K_RD, 32'h2000_0001, 0, 32'h0);
        add_step(K_RD, 32'h4000_0000, 0, 32'h0);
        add_step(K_RD, 32'h4000_0004, 0, 32'h0);
        // Read back plus an unmapped offset and region 3
        add_step(K_WR, 32'h2000_0000, 32'h0000_0003, 0);
        add_step(K_RD, 32'h2000_0000, 0, 32'h0000_0003);
        add_step(K_WR, 32'h2000_0001, 32'h0000_a52c, 0);
        add_step(K_RD, 32'h2000_0001, 0, 32'h0000_002c);
        add_step(K_WR, 32'h4000_0000, 32'h0000_0001, 0);
        add_step(K_RD, 32'h4000_0000, 0, 32'h0000_0001);
        add_step(K_WR, 32'h6000_0000, 32'h0000_00ff, 0);
        add_step(K_RD, 32'h6000_0000, 0, 32'h0);
        add_step(K_RD, 32'h2000_0002, 0, 32'h0);
        // Paced pixels and then a new frame
        for (int i = 0; i < 3; i++)
            add_step(K_PIX, 0, 3, 1);
        add_step(K_DRAIN, 0, 0, 0);
        add_step(K_VS, 0, 0, 0);
        add_step(K_IDLE, 0, 2, 0);
        for (int i = 0; i < 3; i++)
            add_step(K_PIX, 0, 3, 1);
        add_step(K_DRAIN, 0, 0, 0);
        // BGR order
        add_step(K_WR, 32'h2000_0000, 32'h0000_0007, 0);
        for (int i = 0; i < 3; i++)
            add_step(K_PIX, 0, 3, 1);
        add_step(K_DRAIN, 0, 0, 0);
        // Queue overflows with the display off
        add_step(K_WR, 32'h2000_0000, 32'h0000_0002, 0);
        add_step(K_WR, 32'h4000_0004, 32'h0, 0);
        for (int i = 0; i < 6; i++)
            add_step(K_PIX, 0, 0, 0);
        add_step(K_IDLE, 0, 4, 0);
        add_step(K_RD, 32'h4000_0004, 0, 32'h0006_0001);
        add_step(K_WR, 32'h4000_0004, 32'h0, 0);
        add_step(K_RD, 32'h4000_0004, 0, 32'h0);
    endtask

    task automatic cfg_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge sys_clk);
        cfg_we    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        dvp_href  <= 1'b0;
        @(posedge sys_clk);
        cfg_we <= 1'b0;
        if (addr == 32'h2000_0000) begin
            bgr_m = data[2];
            // Display reset follows bit 1 from this edge on
            @(negedge sys_clk);
            checks++;
            if (dbi_resx !== data[1]) begin
                errors++;
                $display("Fail: %0d ns: resx is %b after control write 0x%08h",
                         $time, dbi_resx, data);
            end
        end
        if (addr == 32'h2000_0001)
            cmd_m = data[7:0];
    endtask

    task automatic cfg_read(input logic [31:0] addr, input logic [31:0] exp);
        int n;
        n = 0;
        @(posedge sys_clk);
        cfg_re   <= 1'b1;
        cfg_addr <= addr;
        dvp_href <= 1'b0;
        @(posedge sys_clk);
        cfg_re <= 1'b0;
        @(negedge sys_clk);
        while (!cfg_rvalid && n < 8) begin
            @(negedge sys_clk);
            n++;
        end
        if (!cfg_rvalid) begin
            errors++;
            $display("Timeout: no read data came back for address 0x%08h", addr);
        end else begin
            checks++;
            if (n != 0 || cfg_rdata !== exp) begin
                errors++;
                $display("Fail: %0d ns: read 0x%08h gave 0x%08h (%0d late), expected 0x%08h",
                         $time, addr, cfg_rdata, n, exp);
            end
        end
    endtask

    task automatic drive_byte(input logic [7:0] b);
        @(posedge sys_clk);
        dvp_d    <= b;
        dvp_href <= 1'b1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge sys_clk);
            dvp_href <= 1'b0;
        end
    endtask

    task automatic send_pixel(input int gap, input logic shown);
        logic [15:0] px;
        logic [15:0] px_out;
        px     = 16'($random(seed));
        px_out = bgr_m ? {px[4:0], px[10:5], px[15:11]} : px;    // Red and blue trade places
        if (shown) begin
            if (first_m)
                dbi_exp.push_back({1'b0, cmd_m});
            dbi_exp.push_back({1'b1, px_out[15:8]});
            dbi_exp.push_back({1'b1, px_out[7:0]});
        end
        first_m = 1'b0;
        drive_byte(px[15:8]);
        idle_cycles(gap);
        drive_byte(px[7:0]);
        idle_cycles(gap);
    endtask

    task automatic vsync_pulse();
        @(posedge sys_clk);
        dvp_vsync <= 1'b1;
        dvp_href  <= 1'b0;
        @(posedge sys_clk);
        dvp_vsync <= 1'b0;
        first_m = 1'b1;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        idle_cycles(1);
        @(negedge sys_clk);
        while ((dbi_exp.size() != 0 || !dbi_csx) && n < 400) begin
            @(negedge sys_clk);
            n++;
        end
        if (dbi_exp.size() != 0 || !dbi_csx) begin
            errors++;
            $display("Timeout: display bus still owes %0d bytes", dbi_exp.size());
        end
    endtask

    // Bytes are latched by the display on the rising edge of wrx
    always @(negedge sys_clk) begin
        if (rst_n && dbi_wrx && !wrx_prev) begin
            mon_got = {dbi_dcx, dbi_d};
            if (dbi_csx !== 1'b0) begin
                errors++;
                $display("Fail: %0d ns: byte written while csx is high", $time);
            end
            if (dbi_exp.size() == 0) begin
                errors++;
                $display("Fail: %0d ns: unexpected DBI byte dcx=%0b data=0x%02h",
                         $time, dbi_dcx, dbi_d);
            end else begin
                mon_want = dbi_exp.pop_front();
                checks++;
                if (mon_got !== mon_want) begin
                    errors++;
                    $display("Fail: %0d ns: DBI dcx=%0b data=%02h, expected dcx=%0b data=%02h",
                             $time, mon_got[8], mon_got[7:0], mon_want[8], mon_want[7:0]);
                end
            end
        end
        wrx_prev = dbi_wrx;
    end

    initial begin
        int i;
        seed      = 32'h4507eb0d;
        errors    = 0;
        checks    = 0;
        n_steps   = 0;
        bgr_m     = 1'b0;
        cmd_m     = 8'h00;
        first_m   = 1'b0;
        wrx_prev  = 1'b1;
        rst_n     = 1'b0;
        cfg_we    = 1'b0;
        cfg_re    = 1'b0;
        cfg_addr  = 32'h0;
        cfg_wdata = 32'h0;
        dvp_d     = 8'h00;
        dvp_href  = 1'b0;
        dvp_vsync = 1'b0;
        build_table();

        repeat (5) @(posedge sys_clk);
        rst_n <= 1'b1;
        @(negedge sys_clk);
        checks++;
        if (dbi_csx !== 1'b1 || dbi_wrx !== 1'b1 || dbi_dcx !== 1'b1 ||
            dbi_resx !== 1'b0 || dbi_rdx !== 1'b1) begin
            errors++;
            $display("Fail: %0d ns: bus after reset csx=%b wrx=%b dcx=%b resx=%b rdx=%b",
                     $time, dbi_csx, dbi_wrx, dbi_dcx, dbi_resx, dbi_rdx);
        end
        checks++;
        if (cfg_rvalid !== 1'b0) begin
            errors++;
            $display("Fail: %0d ns: cfg_rvalid is %b after reset", $time, cfg_rvalid);
        end

        for (i = 0; i < n_steps; i++) begin
            case (st_kind[i])
                K_WR:    cfg_write(st_addr[i], st_data[i]);
                K_RD:    cfg_read(st_addr[i], st_exp[i]);
                K_PIX:   send_pixel(int'(st_data[i]), st_exp[i][0]);
                K_IDLE:  idle_cycles(int'(st_data[i]));
                K_VS:    vsync_pulse();
                default: wait_drain();
            endcase
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule
